/* list.f */
ctrl_pkg.sv
boot_ctrl.sv
vita_timer.sv
settings_regs.sv
readback_mux.sv
sys_ctrl_core.sv
tb_sys_ctrl_core.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_sys_ctrl_core
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_sys_ctrl_core.sv */
module tb_sys_ctrl_core;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ACK_TIMEOUT = 20;

   logic                 wb_clk;
   logic                 por_rst;
   ctrl_pkg::bus_adr_t   cpu_adr_i;
   ctrl_pkg::bus_adr_t   mem_adr_o;
   logic                 core_rst_o;
   logic                 bus_stb_i;
   logic                 bus_we_i;
   ctrl_pkg::bus_adr_t   bus_adr_i;
   ctrl_pkg::bus_dat_t   bus_dat_i;
   ctrl_pkg::bus_dat_t   bus_dat_o;
   logic                 bus_ack_o;
   logic                 pps_i;
   logic [3:0]           activity_i;
   logic                 aux_ld1_i;
   logic                 aux_ld2_i;
   logic                 button_i;
   logic [1:0]           lms_res_o;
   logic                 phy_resetn_o;
   logic                 div_sw1_o;
   logic                 div_sw2_o;
   ctrl_pkg::led_t       leds_o;

   logic [31:0]          lfsr;
   longint unsigned      cyc;
   int                   errors;
   int                   timeouts;

   // Reference model of the setting registers and boot phase
   logic [1:0]           m_lms;
   logic                 m_phy_res;
   ctrl_pkg::led_t       m_led_sw;
   ctrl_pkg::led_t       m_led_src;
   logic                 m_div1;
   logic                 m_div2;
   logic                 m_booted;

   ctrl_pkg::set_addr_t  reg_list [6] = '{ctrl_pkg::SR_LMS_RES, ctrl_pkg::SR_PHY_RES,
      ctrl_pkg::SR_LED_SW, ctrl_pkg::SR_LED_SRC, ctrl_pkg::SR_DIVSW1, ctrl_pkg::SR_DIVSW2};

   sys_ctrl_core u_sys_ctrl_core (.*);

   initial begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) cyc <= cyc + 1;

   ////////////////////////////////////////////////////////////
   // Random bits, model and compare tasks
   ////////////////////////////////////////////////////////////

   // Galois LFSR, one step per bit taken
   function automatic ctrl_pkg::bus_dat_t rand_bits(input int n);
      ctrl_pkg::bus_dat_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic void model_reset();
      m_lms     = 2'b00;
      m_phy_res = 1'b0;
      m_led_sw  = 8'h00;
      m_led_src = 8'h1E;
      m_div1    = 1'b1;
      m_div2    = 1'b1;
   endfunction

   function automatic void model_write(input ctrl_pkg::set_addr_t a, input ctrl_pkg::bus_dat_t d);
      case (a)
         ctrl_pkg::SR_LMS_RES: m_lms     = d[1:0];
         ctrl_pkg::SR_PHY_RES: m_phy_res = d[0];
         ctrl_pkg::SR_LED_SW:  m_led_sw  = d[7:0];
         ctrl_pkg::SR_LED_SRC: m_led_src = d[7:0];
         ctrl_pkg::SR_DIVSW1:  m_div1    = d[0];
         ctrl_pkg::SR_DIVSW2:  m_div2    = d[0];
         default: ;
      endcase
   endfunction

   // Mask bit high shows the activity LED, low the software LED
   function automatic ctrl_pkg::led_t expect_leds(input logic [3:0] act);
      ctrl_pkg::led_t hw;
      ctrl_pkg::led_t r;
      hw = {3'b000, act, 1'b0};
      for (int i = 0; i < 8; i++) begin
         r[i] = m_led_src[i] ? hw[i] : m_led_sw[i];
      end
      return r;
   endfunction

   task automatic check_dat(input string what, input ctrl_pkg::bus_dat_t got,
                            input ctrl_pkg::bus_dat_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_adr(input ctrl_pkg::bus_adr_t cpu, input ctrl_pkg::bus_adr_t got,
                            input ctrl_pkg::bus_adr_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error at %0d ns: cpu address %h maps to %h, expected %h",
                  $time, cpu, got, exp);
      end
   endtask

   task automatic check_leds(input ctrl_pkg::led_t got, input ctrl_pkg::led_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error at %0d ns: leds are %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic check_time(input string what, input ctrl_pkg::vita_time_t got,
                             input ctrl_pkg::vita_time_t lo, input ctrl_pkg::vita_time_t hi);
      if ($isunknown(got) || got < lo || got > hi) begin
         errors++;
         $display("** Error at %0d ns: %s is %h, expected %h to %h", $time, what, got, lo, hi);
      end
   endtask

   task automatic check_settings();
      check_dat("setting outputs", {27'b0, lms_res_o, phy_resetn_o, div_sw1_o, div_sw2_o},
                {27'b0, m_lms, ~m_phy_res, m_div1, m_div2});
      check_leds(leds_o, expect_leds(activity_i));
   endtask

   ////////////////////////////////////////////////////////////
   // Bus access
   ////////////////////////////////////////////////////////////

   task automatic bus_access(input logic we, input ctrl_pkg::bus_adr_t adr,
                             input ctrl_pkg::bus_dat_t wdat, output ctrl_pkg::bus_dat_t rdat);
      int n;
      n = 0;
      @(posedge wb_clk);
      bus_stb_i <= 1'b1;
      bus_we_i  <= we;
      bus_adr_i <= adr;
      bus_dat_i <= wdat;
      do begin
         @(posedge wb_clk);
         n++;
      end while (!bus_ack_o && n < ACK_TIMEOUT);
      rdat = bus_dat_o;
      if (!bus_ack_o) begin
         timeouts++;
         $display("Timeout: no bus ack for address %h at %0d ns", adr, $time);
      end
      bus_stb_i <= 1'b0;
      bus_we_i  <= 1'b0;
   endtask

   task automatic set_write(input ctrl_pkg::set_addr_t a, input ctrl_pkg::bus_dat_t d);
      ctrl_pkg::bus_dat_t unused;
      bus_access(1'b1, ctrl_pkg::SET_REGION_BASE | {6'b0, a, 2'b00}, d, unused);
   endtask

   task automatic rb_read(input logic [3:0] idx, output ctrl_pkg::bus_dat_t d);
      bus_access(1'b0, ctrl_pkg::RB_REGION_BASE | {10'b0, idx, 2'b00}, '0, d);
   endtask

   // High half first, as the software reads it
   task automatic read_time(input logic [3:0] hi_idx, input logic [3:0] lo_idx,
                            output ctrl_pkg::vita_time_t t);
      ctrl_pkg::bus_dat_t hi;
      ctrl_pkg::bus_dat_t lo;
      rb_read(hi_idx, hi);
      rb_read(lo_idx, lo);
      t = {hi, lo};
   endtask

   task automatic check_swap(input int n);
      ctrl_pkg::bus_dat_t r;
      ctrl_pkg::bus_adr_t a;
      for (int i = 0; i < n; i++) begin
         r = rand_bits(16);
         a = r[15:0];
         @(posedge wb_clk);
         cpu_adr_i <= a;
         @(posedge wb_clk);
         if (a[15] == a[14] && !m_booted) begin
            check_adr(a, mem_adr_o, a ^ 16'hC000);
         end else begin
            check_adr(a, mem_adr_o, a);
         end
      end
   endtask

   task automatic pps_pulse();
      @(posedge wb_clk);
      pps_i <= 1'b1;
      repeat (3) @(posedge wb_clk);
      pps_i <= 1'b0;
      @(posedge wb_clk);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      ctrl_pkg::bus_dat_t   d;
      ctrl_pkg::bus_dat_t   r;
      ctrl_pkg::vita_time_t v;
      ctrl_pkg::vita_time_t t;
      ctrl_pkg::vita_time_t snap;
      ctrl_pkg::set_addr_t  a;
      longint unsigned      c0;
      int                   pulses;
      logic [3:0]           w;
      lfsr       = 32'h24c2df4a;
      cyc        = 0;
      errors     = 0;
      timeouts   = 0;
      por_rst    = 1'b1;
      cpu_adr_i  = '0;
      bus_stb_i  = 1'b0;
      bus_we_i   = 1'b0;
      bus_adr_i  = '0;
      bus_dat_i  = '0;
      pps_i      = 1'b0;
      activity_i = '0;
      aux_ld1_i  = 1'b0;
      aux_ld2_i  = 1'b0;
      button_i   = 1'b0;
      model_reset();
      m_booted = 1'b0;

      repeat (2) @(posedge wb_clk);
      por_rst <= 1'b0;
      @(posedge wb_clk);
      c0 = cyc;
      check_dat("core reset after por", {31'b0, core_rst_o}, 32'd1);
      @(posedge wb_clk);
      check_dat("core reset one cycle later", {31'b0, core_rst_o}, 32'd0);
      check_dat("bus ack at idle", {31'b0, bus_ack_o}, 32'd0);

      // Defaults, LEDs under random activity
      for (int i = 0; i < 4; i++) begin
         r = rand_bits(4);
         activity_i <= r[3:0];
         @(posedge wb_clk);
         check_settings();
      end
      rb_read(ctrl_pkg::RB_COMPAT, d);
      check_dat("compat word", d, {16'd9, 16'd0});
      read_time(ctrl_pkg::RB_PPS_HI, ctrl_pkg::RB_PPS_LO, snap);
      check_time("pps snapshot after reset", snap, 64'd0, 64'd0);
      read_time(ctrl_pkg::RB_TIME_HI, ctrl_pkg::RB_TIME_LO, t);
      check_time("time after reset", t, 64'd0, cyc - c0);
      r = rand_bits(4);
      w = (r[3:0] > 4'd9) ? r[3:0] - 4'd6 : r[3:0];
      rb_read(w, d);
      check_dat("unused readback word", d, 32'd0);

      check_swap(12);

      // Random setting writes while still booting
      for (int i = 0; i < 16; i++) begin
         r = rand_bits(3);
         a = reg_list[int'(r[2:0]) % 6];
         d = rand_bits(32);
         set_write(a, d);
         model_write(a, d);
         @(posedge wb_clk);
         r = rand_bits(4);
         activity_i <= r[3:0];
         @(posedge wb_clk);
         check_settings();
      end

      // Bootloader done gives one more core reset pulse
      set_write(ctrl_pkg::SR_BLDR_DONE, 32'd1);
      pulses = 0;
      for (int i = 0; i < 12; i++) begin
         @(posedge wb_clk);
         if (core_rst_o) pulses++;
      end
      if (pulses == 0) begin
         timeouts++;
         $display("Timeout: no core reset pulse after bootloader done");
      end
      check_dat("core reset pulses", pulses, 32'd1);
      model_reset();
      m_booted = 1'b1;
      check_settings();
      check_swap(8);

      // Lock detect and button status word
      for (int i = 0; i < 8; i++) begin
         r = rand_bits(3);
         @(posedge wb_clk);
         aux_ld1_i <= r[0];
         aux_ld2_i <= r[1];
         button_i  <= r[2];
         rb_read(ctrl_pkg::RB_IRQ, d);
         check_dat("status word", d, {16'b0, r[1], r[0], r[2], 13'b0});
      end

      // Immediate load, low half kept clear of a carry between the two reads
      v = {rand_bits(32), rand_bits(32)};
      v[31] = 1'b0;
      set_write(ctrl_pkg::SR_TIME_HI, v[63:32]);
      set_write(ctrl_pkg::SR_TIME_LO, v[31:0]);
      c0 = cyc;
      set_write(ctrl_pkg::SR_TIME_CTRL, 32'd1);
      read_time(ctrl_pkg::RB_TIME_HI, ctrl_pkg::RB_TIME_LO, t);
      check_time("time after load", t, v, v + (cyc - c0));
      pps_pulse();
      read_time(ctrl_pkg::RB_PPS_HI, ctrl_pkg::RB_PPS_LO, snap);
      read_time(ctrl_pkg::RB_TIME_HI, ctrl_pkg::RB_TIME_LO, t);
      check_time("pps snapshot", snap, v, t);

      // Load armed for the next PPS edge, which comes some cycles later
      v = {rand_bits(32), rand_bits(32)};
      v[31] = 1'b0;
      set_write(ctrl_pkg::SR_TIME_HI, v[63:32]);
      set_write(ctrl_pkg::SR_TIME_LO, v[31:0]);
      set_write(ctrl_pkg::SR_TIME_CTRL, 32'd0);
      repeat (8) @(posedge wb_clk);
      c0 = cyc;
      pps_pulse();
      read_time(ctrl_pkg::RB_TIME_HI, ctrl_pkg::RB_TIME_LO, t);
      check_time("time after armed load", t, v, v + (cyc - c0));

      $display("Run complete: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* sys_ctrl_core.sv */
module sys_ctrl_core (
   input  logic               wb_clk,
   input  logic               por_rst,
   input  ctrl_pkg::bus_adr_t cpu_adr_i,
   output ctrl_pkg::bus_adr_t mem_adr_o,
   output logic               core_rst_o,
   // Processor bus
   input  logic               bus_stb_i,
   input  logic               bus_we_i,
   input  ctrl_pkg::bus_adr_t bus_adr_i,
   input  ctrl_pkg::bus_dat_t bus_dat_i,
   output ctrl_pkg::bus_dat_t bus_dat_o,
   output logic               bus_ack_o,
   // Status and timing
   input  logic               pps_i,
   input  logic [3:0]         activity_i,
   input  logic               aux_ld1_i,
   input  logic               aux_ld2_i,
   input  logic               button_i,
   // Setting outputs
   output logic [1:0]         lms_res_o,
   output logic               phy_resetn_o,
   output logic               div_sw1_o,
   output logic               div_sw2_o,
   output ctrl_pkg::led_t     leds_o
);

   logic                 bldr_done;
   logic                 set_ack;
   logic                 rb_ack;
   ctrl_pkg::bus_dat_t   rb_dat;
   ctrl_pkg::set_bus_t   set_bus;
   ctrl_pkg::vita_time_t vita_time;
   ctrl_pkg::vita_time_t vita_time_pps;

   boot_ctrl u_boot_ctrl (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .cpu_adr_i   (cpu_adr_i),
      .core_rst_o  (core_rst_o),
      .mem_adr_o   (mem_adr_o)
   );

   settings_regs u_settings_regs (
      .wb_clk       (wb_clk),
      .rst_i        (core_rst_o),
      .bus_stb_i    (bus_stb_i),
      .bus_we_i     (bus_we_i),
      .bus_adr_i    (bus_adr_i),
      .bus_dat_i    (bus_dat_i),
      .ack_o        (set_ack),
      .set_o        (set_bus),
      .activity_i   (activity_i),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .bldr_done_o  (bldr_done),
      .div_sw1_o    (div_sw1_o),
      .div_sw2_o    (div_sw2_o),
      .leds_o       (leds_o)
   );

   vita_timer u_vita_timer (
      .wb_clk     (wb_clk),
      .rst_i      (core_rst_o),
      .set_i      (set_bus),
      .pps_i      (pps_i),
      .time_o     (vita_time),
      .time_pps_o (vita_time_pps)
   );

   readback_mux u_readback_mux (
      .wb_clk     (wb_clk),
      .rst_i      (core_rst_o),
      .bus_stb_i  (bus_stb_i),
      .bus_adr_i  (bus_adr_i),
      .aux_ld1_i  (aux_ld1_i),
      .aux_ld2_i  (aux_ld2_i),
      .button_i   (button_i),
      .time_i     (vita_time),
      .time_pps_i (vita_time_pps),
      .dat_o      (rb_dat),
      .ack_o      (rb_ack)
   );

   // Settings window reads as zero, so only readback data reaches the bus
   assign bus_ack_o = set_ack | rb_ack;
   assign bus_dat_o = rb_dat;

endmodule

/* readback_mux.sv */
module readback_mux (
   input  logic                 wb_clk,
   input  logic                 rst_i,
   input  logic                 bus_stb_i,
   input  ctrl_pkg::bus_adr_t   bus_adr_i,
   input  logic                 aux_ld1_i,
   input  logic                 aux_ld2_i,
   input  logic                 button_i,
   input  ctrl_pkg::vita_time_t time_i,
   input  ctrl_pkg::vita_time_t time_pps_i,
   output ctrl_pkg::bus_dat_t   dat_o,
   output logic                 ack_o
);

   logic               win_hit;
   logic [3:0]         word_idx;
   ctrl_pkg::bus_dat_t word;

   assign win_hit = bus_stb_i &&
      ((bus_adr_i & ctrl_pkg::RB_REGION_MASK) == ctrl_pkg::RB_REGION_BASE);
   assign word_idx = bus_adr_i[5:2];

   ////////////////////////////////////////////////////////////
   // Word select
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (word_idx)
         ctrl_pkg::RB_TIME_HI: word = time_i[63:32];
         ctrl_pkg::RB_TIME_LO: word = time_i[31:0];
         ctrl_pkg::RB_COMPAT:  word = ctrl_pkg::COMPAT_NUM;
         // Lock detects and button in bits 15..13
         ctrl_pkg::RB_IRQ:     word = {16'b0, aux_ld2_i, aux_ld1_i, button_i, 13'b0};
         ctrl_pkg::RB_PPS_HI:  word = time_pps_i[63:32];
         ctrl_pkg::RB_PPS_LO:  word = time_pps_i[31:0];
         default:              word = '0;
      endcase
   end

   // Data is only non-zero in the ack cycle so the top can OR it
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         ack_o <= 1'b0;
         dat_o <= '0;
      end else begin
         ack_o <= win_hit & ~ack_o;
         dat_o <= (win_hit & ~ack_o) ? word : '0;
      end
   end

endmodule

/* settings_regs.sv */
module settings_regs (
   input  logic               wb_clk,
   input  logic               rst_i,
   input  logic               bus_stb_i,
   input  logic               bus_we_i,
   input  ctrl_pkg::bus_adr_t bus_adr_i,
   input  ctrl_pkg::bus_dat_t bus_dat_i,
   output logic               ack_o,
   output ctrl_pkg::set_bus_t set_o,
   input  logic [3:0]         activity_i,
   output logic [1:0]         lms_res_o,
   output logic               phy_resetn_o,
   output logic               bldr_done_o,
   output logic               div_sw1_o,
   output logic               div_sw2_o,
   output ctrl_pkg::led_t     leds_o
);

   logic           win_hit;
   logic           phy_reset;
   ctrl_pkg::led_t led_sw;
   ctrl_pkg::led_t led_src;
   ctrl_pkg::led_t led_hw;

   ////////////////////////////////////////////////////////////
   // Bus to settings strobe
   ////////////////////////////////////////////////////////////

   assign win_hit = bus_stb_i &&
      ((bus_adr_i & ctrl_pkg::SET_REGION_MASK) == ctrl_pkg::SET_REGION_BASE);

   always_ff @(posedge wb_clk) begin
      // Address and data are qualified by stb
      set_o.addr <= bus_adr_i[9:2];
      set_o.data <= bus_dat_i;
      if (rst_i) begin
         ack_o     <= 1'b0;
         set_o.stb <= 1'b0;
      end else begin
         // Master still holds stb in the ack cycle, so skip it
         ack_o     <= win_hit & ~ack_o;
         set_o.stb <= win_hit & ~ack_o & bus_we_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Misc and diversity registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         lms_res_o   <= '0;
         phy_reset   <= 1'b0;
         bldr_done_o <= 1'b0;
         led_sw      <= '0;
         led_src     <= ctrl_pkg::LED_SRC_AT_RESET;
         div_sw1_o   <= ctrl_pkg::DIVSW_AT_RESET;
         div_sw2_o   <= ctrl_pkg::DIVSW_AT_RESET;
      end else if (set_o.stb) begin
         case (set_o.addr)
            ctrl_pkg::SR_LMS_RES:   lms_res_o   <= set_o.data[1:0];
            ctrl_pkg::SR_LED_SW:    led_sw      <= set_o.data[7:0];
            ctrl_pkg::SR_PHY_RES:   phy_reset   <= set_o.data[0];
            ctrl_pkg::SR_BLDR_DONE: bldr_done_o <= set_o.data[0];
            ctrl_pkg::SR_LED_SRC:   led_src     <= set_o.data[7:0];
            ctrl_pkg::SR_DIVSW1:    div_sw1_o   <= set_o.data[0];
            ctrl_pkg::SR_DIVSW2:    div_sw2_o   <= set_o.data[0];
            default: ;
         endcase
      end
   end

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////////////////////////
   // LED mixer
   ////////////////////////////////////////////////////////////

   // Activity lines sit on LEDs 4..1
   assign led_hw = {3'b000, activity_i, 1'b0};

   // Mask bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   a_ack_single: assert property (@(posedge wb_clk) disable iff (rst_i)
      ack_o |=> !ack_o);

endmodule

/* vita_timer.sv */
module vita_timer (
   input  logic                 wb_clk,
   input  logic                 rst_i,
   input  ctrl_pkg::set_bus_t   set_i,
   input  logic                 pps_i,
   output ctrl_pkg::vita_time_t time_o,
   output ctrl_pkg::vita_time_t time_pps_o
);

   ctrl_pkg::bus_dat_t pend_hi;
   ctrl_pkg::bus_dat_t pend_lo;
   logic               armed;
   logic               pps_d;
   logic               pps_edge;
   logic               ctrl_wr;
   logic               load;

   ////////////////////////////////////////////////////////////
   // Settings decode
   ////////////////////////////////////////////////////////////

   assign ctrl_wr  = set_i.stb && (set_i.addr == ctrl_pkg::SR_TIME_CTRL);
   assign pps_edge = pps_i & ~pps_d;

   // Immediate load, or an armed load meeting its PPS edge
   assign load = (ctrl_wr && set_i.data[0]) || (armed && pps_edge);

   // Pending halves of the next load value
   always_ff @(posedge wb_clk) begin
      if (set_i.stb && (set_i.addr == ctrl_pkg::SR_TIME_HI)) begin
         pend_hi <= set_i.data;
      end
      if (set_i.stb && (set_i.addr == ctrl_pkg::SR_TIME_LO)) begin
         pend_lo <= set_i.data;
      end
   end

   ////////////////////////////////////////////////////////////
   // Counter, arming and PPS snapshot
   ////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         time_o     <= '0;
         time_pps_o <= '0;
         armed      <= 1'b0;
         pps_d      <= 1'b0;
      end else begin
         pps_d <= pps_i;

         if (load) begin
            time_o <= {pend_hi, pend_lo};
         end else begin
            time_o <= time_o + 64'd1;
         end

         // A new control write overrides any pending arm
         if (ctrl_wr) begin
            armed <= ~set_i.data[0];
         end else if (pps_edge) begin
            armed <= 1'b0;
         end

         if (pps_edge) begin
            time_pps_o <= time_o;
         end
      end
   end

   a_time_step: assert property (@(posedge wb_clk) disable iff (rst_i)
      (!rst_i && !load) |=> (time_o == $past(time_o) + 64'd1));

endmodule

/* boot_ctrl.sv */
module boot_ctrl (
   input  logic               wb_clk,
   input  logic               por_rst,
   input  logic               bldr_done_i,
   input  ctrl_pkg::bus_adr_t cpu_adr_i,
   output logic               core_rst_o,
   output ctrl_pkg::bus_adr_t mem_adr_o
);

   ctrl_pkg::boot_state_e state;

   ////////////////////////////////////////////////////////////
   // Bootloader FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state      <= ctrl_pkg::BOOT_WAIT;
         core_rst_o <= 1'b1;
      end else begin
         case (state)
            ctrl_pkg::BOOT_WAIT: begin
               // Second core reset once the bootloader hands over
               core_rst_o <= bldr_done_i;
               if (bldr_done_i) begin
                  state <= ctrl_pkg::BOOT_DONE;
               end
            end
            ctrl_pkg::BOOT_DONE: begin
               // Stays here until power-on reset
               core_rst_o <= 1'b0;
            end
         endcase
      end
   end

   // Swap top quarter and bottom quarter while booting
   always_comb begin
      if ((cpu_adr_i[15] == cpu_adr_i[14]) && (state == ctrl_pkg::BOOT_WAIT)) begin
         mem_adr_o = cpu_adr_i ^ ctrl_pkg::BOOT_SWAP_MASK;
      end else begin
         mem_adr_o = cpu_adr_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // The core reset clears bldr_done in the settings block, so no second cycle
   a_core_rst_pulse: assert property (@(posedge wb_clk) disable iff (por_rst)
      (core_rst_o && !por_rst) |=> !core_rst_o);

   a_boot_done_final: assert property (@(posedge wb_clk) disable iff (por_rst)
      (state == ctrl_pkg::BOOT_DONE) |=> (state == ctrl_pkg::BOOT_DONE));

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // Bus and data widths
   ////////////////////////////////////////////////////////////

   // Byte address on the processor bus
   typedef logic [15:0] bus_adr_t;
   typedef logic [31:0] bus_dat_t;

   // Settings register number, taken from byte address bits 9..2
   typedef logic [7:0]  set_addr_t;

   typedef logic [63:0] vita_time_t;
   typedef logic [7:0]  led_t;

   // One settings bus transfer
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      bus_dat_t  data;
   } set_bus_t;

   // Bootloader phase
   typedef enum logic {
      BOOT_WAIT = 1'b0,
      BOOT_DONE = 1'b1
   } boot_state_e;

   ////////////////////////////////////////////////////////////
   // Settings register map
   ////////////////////////////////////////////////////////////

   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd10;
   localparam set_addr_t SR_DIVSW  = 8'd180;

   localparam set_addr_t SR_LMS_RES   = SR_MISC + 8'd0;
   localparam set_addr_t SR_LED_SW    = SR_MISC + 8'd3;
   localparam set_addr_t SR_PHY_RES   = SR_MISC + 8'd4;
   localparam set_addr_t SR_BLDR_DONE = SR_MISC + 8'd5;
   localparam set_addr_t SR_LED_SRC   = SR_MISC + 8'd6;

   localparam set_addr_t SR_TIME_HI   = SR_TIME64 + 8'd0;
   localparam set_addr_t SR_TIME_LO   = SR_TIME64 + 8'd1;
   localparam set_addr_t SR_TIME_CTRL = SR_TIME64 + 8'd2;

   localparam set_addr_t SR_DIVSW1 = SR_DIVSW + 8'd0;
   localparam set_addr_t SR_DIVSW2 = SR_DIVSW + 8'd1;

   ////////////////////////////////////////////////////////////
   // Bus regions and readback words
   ////////////////////////////////////////////////////////////

   // Settings window, 4K at 0x7000
   localparam bus_adr_t SET_REGION_BASE = 16'h7000;
   localparam bus_adr_t SET_REGION_MASK = 16'hF000;

   // Readback window, 1K at 0x5C00
   localparam bus_adr_t RB_REGION_BASE = 16'h5C00;
   localparam bus_adr_t RB_REGION_MASK = 16'hFC00;

   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_IRQ     = 4'd13;
   localparam logic [3:0] RB_PPS_HI  = 4'd14;
   localparam logic [3:0] RB_PPS_LO  = 4'd15;

   // Major in the upper half, minor in the lower
   localparam bus_dat_t COMPAT_NUM = {16'd9, 16'd0};

   localparam led_t LED_SRC_AT_RESET = 8'h1E;
   localparam logic DIVSW_AT_RESET   = 1'b1;

   // Boot RAM and main RAM exchange places while booting
   localparam bus_adr_t BOOT_SWAP_MASK = 16'hC000;

endpackage
